// ==== dside_pkg.sv ====
// Shared types and sizes of the data side. One command is in flight at a time.
// Byte addresses at or above MemLimit are out of range and return an error.
package dside_pkg;

  //////////////////////////////
  // Widths and sizes
  //////////////////////////////

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0]  be_t;
  typedef logic [1:0]  half_t;

  localparam int unsigned MemWords    = 256;
  localparam int unsigned MemIdxW     = $clog2(MemWords);
  localparam addr_t       MemLimit    = addr_t'(4 * MemWords);
  localparam logic [7:0]  GntLfsrSeed = 8'h5b;
  // Longest run of refused grants.
  localparam int unsigned GntMaxStall = 3;

  // Half tags of a bus request.
  localparam half_t HalfSingle = 2'd0;
  localparam half_t HalfFirst  = 2'd1;
  localparam half_t HalfSecond = 2'd2;

  //////////////////////////////
  // Enums and structs
  //////////////////////////////

  typedef enum logic [1:0] {
    SIZE_BYTE,
    SIZE_HALF,
    SIZE_WORD
  } acc_size_e;

  typedef struct packed {
    logic      store;
    acc_size_e size;
    logic      sign;
    addr_t     addr;
    word_t     wdata;
  } dside_cmd_t;

  typedef struct packed {
    logic  store;
    addr_t addr;
    be_t   be;
    word_t wdata;
    half_t half;
  } dmem_req_t;

  typedef struct packed {
    logic  store;
    addr_t addr;
    be_t   be;
    word_t data;
    logic  err;
    logic  misaligned_first;
    logic  misaligned_second;
    logic  first_saw_error;
  } dside_access_t;

  typedef enum logic [2:0] {
    IDLE,
    REQ_FIRST,
    WAIT_FIRST,
    REQ_SECOND,
    WAIT_SECOND
  } port_state_e;

endpackage

// ==== lsu_cmd_decode.sv ====
// Registered decode: req_load_o pulses one cycle after an accepted strobe.
// Strobes while busy_i is high are dropped. The command is held until the next one.
`timescale 1ns/1ns

module lsu_cmd_decode (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  cmd_valid_i,
  input  dside_pkg::dside_cmd_t cmd_i,
  input  logic                  busy_i,
  output logic                  req_load_o,
  output logic                  split_o,
  output dside_pkg::dmem_req_t  req_first_o,
  output dside_pkg::dmem_req_t  req_second_o,
  output dside_pkg::acc_size_e  size_o,
  output logic                  sign_o,
  output logic [1:0]            offset_o
);

  logic              accept;
  logic [1:0]        offset;
  dside_pkg::be_t    base_be;
  logic [7:0]        be_wide;
  logic [63:0]       data_wide;
  logic              split_d;
  dside_pkg::addr_t  word_addr;

  assign accept    = cmd_valid_i & ~busy_i;
  assign offset    = cmd_i.addr[1:0];
  assign word_addr = {cmd_i.addr[31:2], 2'b00};

  always_comb begin
    case (cmd_i.size)
      dside_pkg::SIZE_BYTE: base_be = 4'b0001;
      dside_pkg::SIZE_HALF: base_be = 4'b0011;
      default:              base_be = 4'b1111;
    endcase
  end

  // Move enables and data into lane position.
  assign be_wide   = {4'b0000, base_be} << offset;
  assign data_wide = {32'b0, cmd_i.wdata} << {offset, 3'b000};
  assign split_d   = |be_wide[7:4];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_load_o <= 1'b0;
    end else begin
      req_load_o <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      split_o            <= split_d;
      size_o             <= cmd_i.size;
      sign_o             <= cmd_i.sign;
      offset_o           <= offset;
      req_first_o.store  <= cmd_i.store;
      req_first_o.addr   <= word_addr;
      req_first_o.be     <= be_wide[3:0];
      req_first_o.wdata  <= data_wide[31:0];
      req_first_o.half   <= split_d ? dside_pkg::HalfFirst : dside_pkg::HalfSingle;
      // Spilled lanes go to the next word.
      req_second_o.store <= cmd_i.store;
      req_second_o.addr  <= word_addr + 32'd4;
      req_second_o.be    <= be_wide[7:4];
      req_second_o.wdata <= data_wide[63:32];
      req_second_o.half  <= dside_pkg::HalfSecond;
    end
  end

endmodule

// ==== dmem_bus_port.sv ====
// Bus master for one command: one outstanding transaction, second half after first rvalid.
// busy_o covers the cycle of req_load_i and drops in the cycle after done_i.
`timescale 1ns/1ns

module dmem_bus_port (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_load_i,
  input  logic                 split_i,
  input  dside_pkg::dmem_req_t req_first_i,
  input  dside_pkg::dmem_req_t req_second_i,
  input  logic                 done_i,
  input  logic                 dmem_gnt_i,
  input  logic                 dmem_rvalid_i,
  output logic                 dmem_req_o,
  output dside_pkg::dmem_req_t dmem_o,
  output logic                 busy_o
);

  dside_pkg::port_state_e state_q, state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      dside_pkg::IDLE: begin
        if (req_load_i) begin
          state_d = dside_pkg::REQ_FIRST;
        end
      end
      dside_pkg::REQ_FIRST: begin
        if (dmem_gnt_i) begin
          state_d = dside_pkg::WAIT_FIRST;
        end
      end
      dside_pkg::WAIT_FIRST: begin
        if (done_i) begin
          state_d = dside_pkg::IDLE;
        end else if (dmem_rvalid_i && split_i) begin
          state_d = dside_pkg::REQ_SECOND;
        end
      end
      dside_pkg::REQ_SECOND: begin
        if (dmem_gnt_i) begin
          state_d = dside_pkg::WAIT_SECOND;
        end
      end
      dside_pkg::WAIT_SECOND: begin
        if (done_i) begin
          state_d = dside_pkg::IDLE;
        end
      end
      default: state_d = dside_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= dside_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign dmem_req_o = (state_q == dside_pkg::REQ_FIRST) ||
                      (state_q == dside_pkg::REQ_SECOND);

  // Decode holds both halves stable while busy.
  assign dmem_o = ((state_q == dside_pkg::REQ_SECOND) ||
                   (state_q == dside_pkg::WAIT_SECOND)) ? req_second_i : req_first_i;

  assign busy_o = req_load_i | (state_q != dside_pkg::IDLE);

endmodule

// ==== dmem_ram.sv ====
// Word memory target. Grant stalls follow an LFSR and are capped at GntMaxStall cycles.
// Out-of-range accesses return err with zero data and never write.
`timescale 1ns/1ns

module dmem_ram (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 dmem_req_i,
  input  dside_pkg::dmem_req_t dmem_i,
  output logic                 dmem_gnt_o,
  output logic                 dmem_rvalid_o,
  output dside_pkg::word_t     dmem_rdata_o,
  output logic                 dmem_err_o
);

  logic [7:0]                    lfsr_q;
  logic                          lfsr_fb;
  logic [1:0]                    stall_q;
  logic                          xfer;
  logic                          in_range;
  logic [dside_pkg::MemIdxW-1:0] idx;
  dside_pkg::word_t              mem_q [dside_pkg::MemWords];

  assign lfsr_fb    = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];
  assign dmem_gnt_o = dmem_req_i &
                      ((|lfsr_q[1:0]) | (stall_q == 2'(dside_pkg::GntMaxStall)));
  assign xfer       = dmem_req_i & dmem_gnt_o;
  assign in_range   = dmem_i.addr < dside_pkg::MemLimit;
  assign idx        = dmem_i.addr[2 +: dside_pkg::MemIdxW];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q        <= dside_pkg::GntLfsrSeed;
      stall_q       <= '0;
      dmem_rvalid_o <= 1'b0;
    end else begin
      lfsr_q        <= {lfsr_q[6:0], lfsr_fb};
      dmem_rvalid_o <= xfer;
      if (xfer || !dmem_req_i) begin
        stall_q <= '0;
      end else begin
        stall_q <= stall_q + 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < dside_pkg::MemWords; i++) begin
        mem_q[i] <= '0;
      end
    end else if (xfer && in_range && dmem_i.store) begin
      for (int b = 0; b < 4; b++) begin
        if (dmem_i.be[b]) begin
          mem_q[idx][8*b +: 8] <= dmem_i.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (xfer) begin
      dmem_err_o   <= ~in_range;
      dmem_rdata_o <= (in_range && !dmem_i.store) ? mem_q[idx] : '0;
    end
  end

endmodule

// ==== dside_access_tracker.sv ====
// Pairs each granted request with its response, one record per bus transaction.
// Assumes at most one outstanding transaction; the record is valid with rvalid.
`timescale 1ns/1ns

module dside_access_tracker (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     dmem_req_i,
  input  logic                     dmem_gnt_i,
  input  dside_pkg::dmem_req_t     dmem_i,
  input  logic                     dmem_rvalid_i,
  input  dside_pkg::word_t         dmem_rdata_i,
  input  logic                     dmem_err_i,
  output logic                     acc_valid_o,
  output dside_pkg::dside_access_t acc_o
);

  dside_pkg::dmem_req_t out_q;
  logic                 first_err_q;
  logic                 is_first;
  logic                 is_second;

  // Snapshot of the outstanding request.
  always_ff @(posedge clk_i) begin
    if (dmem_req_i && dmem_gnt_i) begin
      out_q <= dmem_i;
    end
  end

  assign is_first  = out_q.half == dside_pkg::HalfFirst;
  assign is_second = out_q.half == dside_pkg::HalfSecond;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_err_q <= 1'b0;
    end else if (dmem_rvalid_i && is_first) begin
      first_err_q <= dmem_err_i;
    end
  end

  assign acc_valid_o = dmem_rvalid_i;

  always_comb begin
    acc_o.store             = out_q.store;
    acc_o.addr              = out_q.addr;
    acc_o.be                = out_q.be;
    acc_o.data              = out_q.store ? out_q.wdata : dmem_rdata_i;
    acc_o.err               = dmem_err_i;
    acc_o.misaligned_first  = is_first;
    acc_o.misaligned_second = is_second;
    acc_o.first_saw_error   = is_second & first_err_q;
  end

endmodule

// ==== load_result_merge.sv ====
// Builds the load result from one or two records; res_valid_o one cycle after the last.
// Size, sign and offset must stay stable until the last record of the command.
`timescale 1ns/1ns

module load_result_merge (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     acc_valid_i,
  input  dside_pkg::dside_access_t acc_i,
  input  dside_pkg::acc_size_e     size_i,
  input  logic                     sign_i,
  input  logic [1:0]               offset_i,
  output logic                     done_o,
  output logic                     res_valid_o,
  output dside_pkg::word_t         res_data_o,
  output logic                     res_err_o
);

  dside_pkg::word_t lo_q;
  logic [63:0]      joined;
  dside_pkg::word_t shifted;
  dside_pkg::word_t extended;
  logic             last;

  assign last   = acc_valid_i & ~acc_i.misaligned_first;
  assign done_o = last;

  // Lower lanes of a split load.
  always_ff @(posedge clk_i) begin
    if (acc_valid_i && acc_i.misaligned_first) begin
      lo_q <= acc_i.data;
    end
  end

  always_comb begin
    joined  = acc_i.misaligned_second ? {acc_i.data, lo_q} : {32'b0, acc_i.data};
    shifted = 32'(joined >> {offset_i, 3'b000});
    case (size_i)
      dside_pkg::SIZE_BYTE: extended = {{24{sign_i & shifted[7]}}, shifted[7:0]};
      dside_pkg::SIZE_HALF: extended = {{16{sign_i & shifted[15]}}, shifted[15:0]};
      default:              extended = shifted;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_o <= 1'b0;
    end else begin
      res_valid_o <= last;
    end
  end

  always_ff @(posedge clk_i) begin
    if (last) begin
      res_data_o <= acc_i.store ? '0 : extended;
      // First half error travels on the second record.
      res_err_o  <= acc_i.err | acc_i.first_saw_error;
    end
  end

endmodule

// ==== dside_top.sv ====
// Data side of a load/store unit with its word memory. Respect busy_o before a strobe.
`timescale 1ns/1ns

module dside_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     cmd_valid_i,
  input  dside_pkg::dside_cmd_t    cmd_i,
  output logic                     busy_o,
  output logic                     res_valid_o,
  output dside_pkg::word_t         res_data_o,
  output logic                     res_err_o,
  output logic                     acc_valid_o,
  output dside_pkg::dside_access_t acc_o
);

  logic                 req_load;
  logic                 split;
  dside_pkg::dmem_req_t req_first;
  dside_pkg::dmem_req_t req_second;
  dside_pkg::acc_size_e cmd_size;
  logic                 cmd_sign;
  logic [1:0]           cmd_offset;
  logic                 done;
  logic                 dmem_req;
  dside_pkg::dmem_req_t dmem;
  logic                 dmem_gnt;
  logic                 dmem_rvalid;
  dside_pkg::word_t     dmem_rdata;
  logic                 dmem_err;

  lsu_cmd_decode u_decode (
    .clk_i, .rst_ni, .cmd_valid_i, .cmd_i,
    .busy_i      (busy_o),
    .req_load_o  (req_load),
    .split_o     (split),
    .req_first_o (req_first),
    .req_second_o(req_second),
    .size_o      (cmd_size),
    .sign_o      (cmd_sign),
    .offset_o    (cmd_offset)
  );

  dmem_bus_port u_port (
    .clk_i, .rst_ni,
    .req_load_i   (req_load),
    .split_i      (split),
    .req_first_i  (req_first),
    .req_second_i (req_second),
    .done_i       (done),
    .dmem_gnt_i   (dmem_gnt),
    .dmem_rvalid_i(dmem_rvalid),
    .dmem_req_o   (dmem_req),
    .dmem_o       (dmem),
    .busy_o
  );

  dmem_ram u_ram (
    .clk_i, .rst_ni,
    .dmem_req_i   (dmem_req),
    .dmem_i       (dmem),
    .dmem_gnt_o   (dmem_gnt),
    .dmem_rvalid_o(dmem_rvalid),
    .dmem_rdata_o (dmem_rdata),
    .dmem_err_o   (dmem_err)
  );

  dside_access_tracker u_tracker (
    .clk_i, .rst_ni,
    .dmem_req_i   (dmem_req),
    .dmem_gnt_i   (dmem_gnt),
    .dmem_i       (dmem),
    .dmem_rvalid_i(dmem_rvalid),
    .dmem_rdata_i (dmem_rdata),
    .dmem_err_i   (dmem_err),
    .acc_valid_o,
    .acc_o
  );

  load_result_merge u_merge (
    .clk_i, .rst_ni,
    .acc_valid_i(acc_valid_o),
    .acc_i      (acc_o),
    .size_i     (cmd_size),
    .sign_i     (cmd_sign),
    .offset_i   (cmd_offset),
    .done_o     (done),
    .res_valid_o,
    .res_data_o,
    .res_err_o
  );

endmodule

// ==== tb_clk_gen.sv ====
// Free-running 10 ns clock. Reset is held low for the first 4 rising edges.
`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the sampling edge.
  initial begin
    rst_no = 1'b0;
    repeat (4) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// ==== tb_dside_assert.sv ====
// Bus protocol and access record checks, bound into dside_top.
// Assumes one outstanding transaction and a response one cycle after grant.
`timescale 1ns/1ns

module tb_dside_assert (
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     dmem_req_i,
  input logic                     dmem_gnt_i,
  input logic                     dmem_rvalid_i,
  input dside_pkg::dmem_req_t     dmem_i,
  input dside_pkg::port_state_e   state_i,
  input logic                     busy_i,
  input logic                     res_valid_i,
  input logic                     acc_valid_i,
  input dside_pkg::dside_access_t acc_i
);

  //////////////////////////////
  // Bus protocol
  //////////////////////////////

  req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dmem_req_i && !dmem_gnt_i |=> dmem_req_i && $stable(dmem_i))
    else $error("request dropped or changed before grant");

  rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dmem_req_i && dmem_gnt_i |=> dmem_rvalid_i)
    else $error("no rvalid one cycle after grant");

  rvalid_needs_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dmem_rvalid_i |-> $past(dmem_req_i && dmem_gnt_i))
    else $error("rvalid without a grant in the previous cycle");

  single_outstanding: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dmem_req_i && dmem_gnt_i |=> !dmem_gnt_i)
    else $error("second grant while a transaction is outstanding");

  // A first-half record is followed by the second request.
  first_to_second: assert property (@(posedge clk_i) disable iff (!rst_ni)
    acc_valid_i && acc_i.misaligned_first |=> state_i == dside_pkg::REQ_SECOND)
    else $error("second half not requested in the cycle after the first response");

  //////////////////////////////
  // Reset and status
  //////////////////////////////

  reset_quiet: assert property (@(posedge clk_i)
    !rst_ni |-> !busy_i && !dmem_req_i && !res_valid_i && !acc_valid_i)
    else $error("output active during reset");

  busy_fall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(busy_i) |-> res_valid_i)
    else $error("busy fell without a result");

  busy_clear: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid_i |-> !busy_i)
    else $error("busy still high with the result");

endmodule

// ==== tb_dside_top.sv ====
// Load/store commands against a byte model of the data memory, one command at a time.
// Addresses stay below twice the memory size so the second half never wraps.
`timescale 1ns/1ns

module tb_dside_top;

  localparam int          Timeout = 200;
  localparam logic [31:0] Seed    = 32'hf232f053;

  logic                     clk;
  logic                     rst_n;
  logic                     cmd_valid;
  dside_pkg::dside_cmd_t    cmd;
  logic                     busy;
  logic                     res_valid;
  dside_pkg::word_t         res_data;
  logic                     res_err;
  logic                     acc_valid;
  dside_pkg::dside_access_t acc;

  logic [7:0]               model_mem [4*dside_pkg::MemWords];
  dside_pkg::dside_access_t exp_q [$];
  dside_pkg::dside_access_t exp_rec;
  dside_pkg::dside_cmd_t    junk_cmd;
  int                       err_cnt;
  int                       timeout_cnt;
  int                       res_cnt;

  tb_clk_gen u_clk_gen (
    .clk_o (clk),
    .rst_no(rst_n)
  );

  dside_top dut (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .cmd_valid_i(cmd_valid),
    .cmd_i      (cmd),
    .busy_o     (busy),
    .res_valid_o(res_valid),
    .res_data_o (res_data),
    .res_err_o  (res_err),
    .acc_valid_o(acc_valid),
    .acc_o      (acc)
  );

  bind dside_top tb_dside_assert u_assert (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .dmem_req_i   (dmem_req),
    .dmem_gnt_i   (dmem_gnt),
    .dmem_rvalid_i(dmem_rvalid),
    .dmem_i       (dmem),
    .state_i      (u_port.state_q),
    .busy_i       (busy_o),
    .res_valid_i  (res_valid_o),
    .acc_valid_i  (acc_valid_o),
    .acc_i        (acc_o)
  );

  //////////////////////////////
  // Model memory
  //////////////////////////////

  function automatic int nbytes(input dside_pkg::acc_size_e size);
    case (size)
      dside_pkg::SIZE_BYTE: return 1;
      dside_pkg::SIZE_HALF: return 2;
      default:              return 4;
    endcase
  endfunction

  function automatic logic [7:0] model_byte(input dside_pkg::addr_t a);
    return (a < dside_pkg::MemLimit) ? model_mem[a[dside_pkg::MemIdxW+1:0]] : 8'h00;
  endfunction

  function automatic dside_pkg::word_t model_word(input dside_pkg::addr_t a);
    dside_pkg::word_t w;
    for (int b = 0; b < 4; b++) begin
      w[8*b +: 8] = model_byte(a + dside_pkg::addr_t'(b));
    end
    return w;
  endfunction

  function automatic dside_pkg::word_t expect_load(input dside_pkg::dside_cmd_t c);
    dside_pkg::word_t v;
    v = '0;
    for (int b = 0; b < nbytes(c.size); b++) begin
      v[8*b +: 8] = model_byte(c.addr + dside_pkg::addr_t'(b));
    end
    if (c.sign && c.size == dside_pkg::SIZE_BYTE) begin
      v = {{24{v[7]}}, v[7:0]};
    end
    if (c.sign && c.size == dside_pkg::SIZE_HALF) begin
      v = {{16{v[15]}}, v[15:0]};
    end
    return v;
  endfunction

  task automatic model_store(input dside_pkg::dside_cmd_t c);
    dside_pkg::addr_t a;
    for (int b = 0; b < nbytes(c.size); b++) begin
      a = c.addr + dside_pkg::addr_t'(b);
      if (a < dside_pkg::MemLimit) begin
        model_mem[a[dside_pkg::MemIdxW+1:0]] = c.wdata[8*b +: 8];
      end
    end
  endtask

  function automatic dside_pkg::dside_cmd_t make_cmd(input logic store,
      input dside_pkg::acc_size_e size, input logic sign, input dside_pkg::addr_t addr,
      input dside_pkg::word_t wdata);
    dside_pkg::dside_cmd_t c;
    c.store = store;
    c.size  = size;
    c.sign  = sign;
    c.addr  = addr;
    c.wdata = wdata;
    return c;
  endfunction

  // One record per word touched, low word first.
  task automatic push_expected(input dside_pkg::dside_cmd_t c);
    dside_pkg::be_t           be_h [2];
    dside_pkg::word_t         lanes_h [2];
    int                       pos;
    logic                     is_split;
    logic                     first_err;
    dside_pkg::dside_access_t rec;
    be_h[0]    = '0;
    be_h[1]    = '0;
    lanes_h[0] = '0;
    lanes_h[1] = '0;
    // Each store data byte sits in the lane of its own byte address.
    for (int b = 0; b < 4; b++) begin
      pos = int'(c.addr[1:0]) + b;
      lanes_h[pos / 4][8*(pos % 4) +: 8] = c.wdata[8*b +: 8];
      if (b < nbytes(c.size)) begin
        be_h[pos / 4][pos % 4] = 1'b1;
      end
    end
    is_split  = |be_h[1];
    first_err = 1'b0;
    for (int h = 0; h < 2; h++) begin
      if (h == 0 || is_split) begin
        rec.store             = c.store;
        rec.addr              = {c.addr[31:2], 2'b00} + dside_pkg::addr_t'(4 * h);
        rec.be                = be_h[h];
        rec.data              = c.store ? lanes_h[h] : model_word(rec.addr);
        rec.err               = rec.addr >= dside_pkg::MemLimit;
        rec.misaligned_first  = is_split && (h == 0);
        rec.misaligned_second = (h == 1);
        rec.first_saw_error   = (h == 1) && first_err;
        first_err             = rec.err;
        exp_q.push_back(rec);
      end
    end
  endtask

  //////////////////////////////
  // Record monitor
  //////////////////////////////

  always @(negedge clk) begin
    if (rst_n && acc_valid) begin
      if (exp_q.size() == 0) begin
        $display("[ERROR] %0t: unexpected access record %h", $time, acc);
        err_cnt++;
      end else begin
        exp_rec = exp_q.pop_front();
        if (acc !== exp_rec) begin
          $display("[ERROR] %0t: access record %h, expected %h", $time, acc, exp_rec);
          err_cnt++;
        end
      end
    end
    if (rst_n && res_valid) begin
      res_cnt++;
    end
  end

  //////////////////////////////
  // Command driver
  //////////////////////////////

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (busy && cycles < Timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (busy) begin
      $display("Timeout: DUT still busy after %0d cycles at %0t", Timeout, $time);
      timeout_cnt++;
    end
  endtask

  task automatic wait_result();
    int cycles;
    cycles = 0;
    while (!res_valid && cycles < Timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (!res_valid) begin
      $display("Timeout: no result within %0d cycles at %0t", Timeout, $time);
      timeout_cnt++;
    end
  endtask

  task automatic run_cmd(input dside_pkg::dside_cmd_t c, input bit junk);
    dside_pkg::word_t exp_data;
    logic             exp_err;
    int               cnt_before;
    if (timeout_cnt != 0) begin
      return;
    end
    exp_data = c.store ? '0 : expect_load(c);
    exp_err  = (c.addr + dside_pkg::addr_t'(nbytes(c.size) - 1)) >= dside_pkg::MemLimit;
    push_expected(c);
    cnt_before = res_cnt;
    wait_idle();
    if (timeout_cnt != 0) begin
      return;
    end
    cmd_valid = 1'b1;
    cmd       = c;
    @(negedge clk);
    cmd_valid = 1'b0;
    // Further strobes while busy must be dropped.
    if (junk) begin
      repeat (2) begin
        if (busy) begin
          cmd_valid = 1'b1;
          cmd       = junk_cmd;
        end
        @(negedge clk);
        cmd_valid = 1'b0;
      end
    end
    wait_result();
    if (timeout_cnt != 0) begin
      return;
    end
    if (res_data !== exp_data || res_err !== exp_err) begin
      $display("[ERROR] %0t: %s at %h gave %h err %b, expected %h err %b", $time,
               c.store ? "store" : "load", c.addr, res_data, res_err, exp_data, exp_err);
      err_cnt++;
    end
    if (c.store) begin
      model_store(c);
    end
    repeat (2) @(negedge clk);
    if (res_cnt != cnt_before + 1) begin
      $display("[ERROR] %0t: %0d results for one command", $time, res_cnt - cnt_before);
      err_cnt++;
    end
    if (exp_q.size() != 0) begin
      $display("[ERROR] %0t: %0d access records missing", $time, exp_q.size());
      err_cnt++;
      exp_q.delete();
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin : run_tests
    dside_pkg::addr_t a;
    dside_pkg::word_t w;
    cmd_valid   = 1'b0;
    cmd         = '0;
    err_cnt     = 0;
    timeout_cnt = 0;
    res_cnt     = 0;
    void'($urandom(Seed));
    junk_cmd    = make_cmd(1'b1, dside_pkg::SIZE_WORD, 1'b0, 32'h44, 32'hdead_beef);
    for (int i = 0; i < 4 * dside_pkg::MemWords; i++) begin
      model_mem[i] = 8'h00;
    end
    for (int i = 0; i < 20 && rst_n !== 1'b1; i++) begin
      @(negedge clk);
    end
    @(negedge clk);

    // Aligned words.
    repeat (6) begin
      a = dside_pkg::addr_t'($urandom_range(dside_pkg::MemWords - 1)) << 2;
      w = $urandom();
      run_cmd(make_cmd(1'b1, dside_pkg::SIZE_WORD, 1'b0, a, w), 1'b0);
      run_cmd(make_cmd(1'b0, dside_pkg::SIZE_WORD, 1'b0, a, '0), 1'b0);
    end

    // Bytes and halves at every offset, both extensions.
    run_cmd(make_cmd(1'b1, dside_pkg::SIZE_WORD, 1'b0, 32'h20, 32'h8c7f_f081), 1'b0);
    for (int off = 0; off < 4; off++) begin
      for (int s = 0; s < 2; s++) begin
        run_cmd(make_cmd(1'b0, dside_pkg::SIZE_BYTE, s[0], 32'h20 + off, '0), 1'b0);
        if (off < 3) begin
          run_cmd(make_cmd(1'b0, dside_pkg::SIZE_HALF, s[0], 32'h20 + off, '0), 1'b0);
        end
      end
    end
    run_cmd(make_cmd(1'b1, dside_pkg::SIZE_BYTE, 1'b0, 32'h21, 32'h0000_005a), 1'b0);
    run_cmd(make_cmd(1'b1, dside_pkg::SIZE_HALF, 1'b0, 32'h22, 32'h0000_c3e7), 1'b0);
    run_cmd(make_cmd(1'b0, dside_pkg::SIZE_WORD, 1'b0, 32'h20, '0), 1'b0);

    // Accesses across a word boundary.
    for (int off = 1; off < 4; off++) begin
      a = (dside_pkg::addr_t'($urandom_range(dside_pkg::MemWords - 2)) << 2) + off;
      w = $urandom();
      run_cmd(make_cmd(1'b1, dside_pkg::SIZE_WORD, 1'b0, a, w), 1'b0);
      run_cmd(make_cmd(1'b0, dside_pkg::SIZE_WORD, 1'b0, a, '0), 1'b0);
      run_cmd(make_cmd(1'b0, dside_pkg::SIZE_HALF, 1'b1, {a[31:2], 2'b11}, '0), 1'b0);
    end

    // Out of range, fully and in the second half only.
    run_cmd(make_cmd(1'b1, dside_pkg::SIZE_WORD, 1'b0, dside_pkg::MemLimit + 8,
                     32'h1234_5678), 1'b0);
    run_cmd(make_cmd(1'b0, dside_pkg::SIZE_WORD, 1'b0, dside_pkg::MemLimit + 8, '0), 1'b0);
    run_cmd(make_cmd(1'b0, dside_pkg::SIZE_WORD, 1'b0, 32'h8, '0), 1'b0);
    run_cmd(make_cmd(1'b1, dside_pkg::SIZE_WORD, 1'b0, dside_pkg::MemLimit - 2,
                     32'ha5c3_9617), 1'b0);
    run_cmd(make_cmd(1'b0, dside_pkg::SIZE_WORD, 1'b0, dside_pkg::MemLimit - 4, '0), 1'b0);
    run_cmd(make_cmd(1'b0, dside_pkg::SIZE_WORD, 1'b0, dside_pkg::MemLimit + 2, '0), 1'b0);
    run_cmd(make_cmd(1'b0, dside_pkg::SIZE_HALF, 1'b1, dside_pkg::MemLimit - 1, '0), 1'b0);

    // Strobes while busy.
    run_cmd(make_cmd(1'b1, dside_pkg::SIZE_WORD, 1'b0, 32'h80, 32'h0bad_f00d), 1'b1);
    run_cmd(make_cmd(1'b0, dside_pkg::SIZE_WORD, 1'b0, 32'h81, '0), 1'b1);
    run_cmd(make_cmd(1'b0, dside_pkg::SIZE_WORD, 1'b0, 32'h44, '0), 1'b0);

    // Random mix in the low words.
    repeat (30) begin
      a = dside_pkg::addr_t'($urandom_range(127));
      run_cmd(make_cmd(1'($urandom_range(1)), dside_pkg::acc_size_e'($urandom_range(2)),
                       1'($urandom_range(1)), a, $urandom()), 1'b0);
    end

    $display("Checks done: %0d errors, %0d timeouts", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
dside_pkg.sv
lsu_cmd_decode.sv
dmem_bus_port.sv
dmem_ram.sv
dside_access_tracker.sv
load_result_merge.sv
dside_top.sv
tb_clk_gen.sv
tb_dside_assert.sv
tb_dside_top.sv

// ==== Makefile ====
# Verilator simulation of the data-side testbench.
# Override any variable on the command line, for example: make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_dside_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Testbench passed
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# The run passes only if the log holds the pass message on a line of its own.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
